//--- build.f
hdl/pipePkg.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/ex1Stage.sv
hdl/ex2Stage.sv
hdl/pipeTop.sv
tests/pipeTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the pipeline testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module pipeTb -o pipeSim \
	> build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/pipeSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** FAILED ***' sim.log; then
	exit 1
fi
exit 0

//--- tests/pipeTb.sv
// Testbench for the five-stage pipeline top level
// Loads each program during reset, runs it and checks every retirement
// Against an in-order reference model of the four operations
module pipeTb;

	// Opcode nibble, bit 31 down to bit 28
	localparam logic [3:0] OP_NOP  = 4'b0000;
	localparam logic [3:0] OP_MOV  = 4'b1000;
	localparam logic [3:0] OP_SUB3 = 4'b0100;
	localparam logic [3:0] OP_ADD4 = 4'b0010;
	localparam logic [3:0] OP_ADD1 = 4'b0001;

	logic               CLK;
	logic               RSTB;
	pipePkg::imemLoad_t imemLoad;
	logic               wbValid;
	pipePkg::regId_t    wbReg;
	pipePkg::data_t     wbData;

	logic [31:0] prog [64];
	logic [3:0]  expReg [$];
	logic [15:0] expData [$];
	int          strobeCycles [$];
	int          cycle;
	int          errorCount;
	int          testsRun;
	int          testsFailed;
	logic [31:0] lfsrState;

	pipeTop #(
		.ImemAddrBits (6)
	) dut0 (
		.CLK      (CLK),
		.RSTB     (RSTB),
		.imemLoad (imemLoad),
		.wbValid  (wbValid),
		.wbReg    (wbReg),
		.wbData   (wbData)
	);

	always #50 CLK = ~CLK;

	// Clocks since reset release, so address a retires at cycle a + 4 without stalls
	always @(posedge CLK)
	begin
		if (!RSTB)
			cycle <= 0;
		else
			cycle <= cycle + 1;
	end

	// ------------------------------------------------------------------------
	// Checkers
	// ------------------------------------------------------------------------
	noRetireInReset: assert property (@(posedge CLK) !RSTB |-> !wbValid)
	else
	begin
		$display("** Error @ %0t: wbValid high while RSTB is low", $time);
		errorCount++;
	end

	// Outputs are sampled at the falling edge, half a period after they change
	always @(negedge CLK)
	begin
		if (RSTB && wbValid)
		begin
			strobeCycles.push_back(cycle);
			assert (expReg.size() > 0)
			else
			begin
				$display("Unexpected retirement of r%0d at %0t, none was left", wbReg, $time);
				errorCount++;
			end
			if (expReg.size() > 0)
			begin
				assert (wbReg == expReg[0] && wbData == expData[0])
				else
				begin
					$display("** Error @ %0t: retired r%0d = %h, expected r%0d = %h",
						$time, wbReg, wbData, expReg[0], expData[0]);
					errorCount++;
				end
				void'(expReg.pop_front());
				void'(expData.pop_front());
			end
		end
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------
	function automatic logic [31:0] makeInstr(input logic [3:0] op, input int rd, input int rs);
		return {op, 20'b0, rd[3:0], rs[3:0]};
	endfunction

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	// One LFSR step for every bit taken
	task automatic drawBits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			bits = {bits[30:0], lfsrState[0]};
		end
	endtask

	task automatic clearProgram();
		for (int a = 0; a < 64; a++)
			prog[a] = makeInstr(OP_NOP, 0, 0);
	endtask

	// In-order model: every non-NOP word writes its result and retires once
	task automatic buildExpected(input int passes);
		logic [15:0] model [16];
		logic [31:0] w;
		logic [15:0] x;
		for (int r = 0; r < 16; r++)
			model[r] = '0;
		for (int i = 0; i < passes * 64; i++)
		begin
			w = prog[i[5:0]];
			x = model[w[3:0]];
			if (w[31:28] != OP_NOP)
			begin
				if (w[31:28] == OP_SUB3)
					x = x - 16'd3;
				else if (w[31:28] == OP_ADD4)
					x = x + 16'd4;
				else if (w[31:28] == OP_ADD1)
					x = x + 16'd1;
				model[w[7:4]] = x;
				expReg.push_back(w[7:4]);
				expData.push_back(x);
			end
		end
	endtask

	// Reset, load all 64 words while RSTB is low, release and drain the model queue
	task automatic runProgram(input string name, input int passes, input int limit);
		int n;
		expReg.delete();
		expData.delete();
		strobeCycles.delete();
		buildExpected(passes);
		@(posedge CLK);
		RSTB        <= 1'b0;
		imemLoad.we <= 1'b0;
		repeat (10) @(posedge CLK);
		for (int a = 0; a < 64; a++)
		begin
			imemLoad.we   <= 1'b1;
			imemLoad.addr <= a[5:0];
			imemLoad.data <= prog[a];
			@(posedge CLK);
		end
		imemLoad.we <= 1'b0;
		RSTB        <= 1'b1;
		n = 0;
		while (expReg.size() != 0 && n < limit)
		begin
			@(posedge CLK);
			n++;
		end
		if (expReg.size() != 0)
		begin
			$display("Timeout in %s: %0d expected retirements never arrived", name, expReg.size());
			errorCount++;
		end
	endtask

	task automatic checkSpacing(input int gap);
		for (int i = 1; i < strobeCycles.size(); i++)
		begin
			assert (strobeCycles[i] - strobeCycles[i-1] == gap)
			else
			begin
				$display("** Error @ %0t: retirements %0d and %0d are %0d cycles apart, expected %0d",
					$time, i - 1, i, strobeCycles[i] - strobeCycles[i-1], gap);
				errorCount++;
			end
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testsRun++;
		if (errorCount == errBefore)
			$display("Test %s: ok", name);
		else
		begin
			testsFailed++;
			$display("Test %s: %0d error(s)", name, errorCount - errBefore);
		end
	endtask

	// ------------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------------
	task automatic testResetAndMov();
		int errBefore;
		errBefore = errorCount;
		clearProgram();
		// Two NOPs first, so the MOV at address 2 retires at cycle 6
		prog[2] = makeInstr(OP_MOV, 2, 9);
		runProgram("resetAndMov", 1, 100);
		assert (strobeCycles.size() == 1 && strobeCycles[0] == 6)
		else
		begin
			$display("** Error @ %0t: first retirement at cycle %0d, expected cycle 6",
				$time, strobeCycles[0]);
			errorCount++;
		end
		reportTest("resetAndMov", errBefore);
	endtask

	task automatic testIndependent();
		int errBefore;
		errBefore = errorCount;
		clearProgram();
		prog[0] = makeInstr(OP_MOV, 1, 2);
		prog[1] = makeInstr(OP_SUB3, 3, 4);
		prog[2] = makeInstr(OP_ADD4, 5, 6);
		prog[3] = makeInstr(OP_ADD1, 7, 8);
		runProgram("independent", 1, 100);
		checkSpacing(1);
		reportTest("independent", errBefore);
	endtask

	task automatic testForwarding();
		int errBefore;
		errBefore = errorCount;
		clearProgram();
		prog[0] = makeInstr(OP_ADD4, 1, 2);
		// ADD4 one ahead reaches this MOV in execute 2
		prog[1] = makeInstr(OP_MOV, 3, 1);
		// MOV one ahead feeds execute 1 directly
		prog[2] = makeInstr(OP_SUB3, 4, 3);
		// Two apart, taken from write-back
		prog[3] = makeInstr(OP_ADD4, 5, 3);
		prog[4] = makeInstr(OP_MOV, 4, 5);
		prog[5] = makeInstr(OP_ADD1, 9, 1);
		prog[6] = makeInstr(OP_MOV, 9, 5);
		// r9 written one and two ahead, the nearer MOV has to win
		prog[7] = makeInstr(OP_SUB3, 10, 9);
		runProgram("forwarding", 1, 100);
		reportTest("forwarding", errBefore);
	endtask

	task automatic testStall();
		int errBefore;
		errBefore = errorCount;
		clearProgram();
		// Every pair is a late producer followed by an early consumer
		prog[0] = makeInstr(OP_ADD4, 3, 1);
		prog[1] = makeInstr(OP_ADD1, 4, 3);
		prog[2] = makeInstr(OP_SUB3, 6, 4);
		runProgram("stall", 1, 100);
		checkSpacing(2);
		reportTest("stall", errBefore);
	endtask

	task automatic testRegBypass();
		int errBefore;
		errBefore = errorCount;
		clearProgram();
		prog[0] = makeInstr(OP_ADD4, 11, 12);
		prog[3] = makeInstr(OP_MOV, 13, 11);
		prog[4] = makeInstr(OP_ADD1, 2, 0);
		prog[5] = makeInstr(OP_MOV, 6, 7);
		prog[6] = makeInstr(OP_ADD4, 8, 9);
		prog[7] = makeInstr(OP_SUB3, 10, 2);
		runProgram("regBypass", 1, 100);
		reportTest("regBypass", errBefore);
	endtask

	task automatic testRandom();
		int          errBefore;
		logic [31:0] sel;
		logic [31:0] rd;
		logic [31:0] rs;
		logic [3:0]  op;
		errBefore = errorCount;
		// Only eight registers are used, so hazards come up often
		for (int a = 0; a < 64; a++)
		begin
			drawBits(3, sel);
			drawBits(3, rd);
			drawBits(3, rs);
			case (sel[2:0])
				3'd0:         op = OP_NOP;
				3'd1, 3'd7:   op = OP_MOV;
				3'd2:         op = OP_SUB3;
				3'd3, 3'd5:   op = OP_ADD4;
				default:      op = OP_ADD1;
			endcase
			prog[a] = makeInstr(op, int'(rd), int'(rs));
		end
		// Two passes around the wrapped PC
		runProgram("random", 2, 400);
		reportTest("random", errBefore);
	endtask

	initial
	begin
		CLK         = 1'b0;
		RSTB        <= 1'b0;
		imemLoad    <= '0;
		cycle       <= 0;
		errorCount  = 0;
		testsRun    = 0;
		testsFailed = 0;
		lfsrState   = 32'hd021_d2f4;

		testResetAndMov();
		testIndependent();
		testForwarding();
		testStall();
		testRegBypass();
		testRandom();

		$display("Tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- hdl/pipeTop.sv
// Five-stage MOV/SUB3/ADD4/ADD1 pipeline top level
// Load the program through imemLoad while RSTB is low, watch retirements on wb*
module pipeTop
#(
	parameter int ImemAddrBits = 6
)
(
	input  logic                CLK,
	input  logic                RSTB,
	input  pipePkg::imemLoad_t  imemLoad,
	output logic                wbValid,
	output pipePkg::regId_t     wbReg,
	output pipePkg::data_t      wbData
);

	pipePkg::ifIdBus_t   ifId;
	logic                stall;
	pipePkg::regId_t     xa;
	pipePkg::data_t      xd;
	pipePkg::idEx1Bus_t  idEx1;
	pipePkg::opCtrl_t    ex1Ctrl;
	pipePkg::regId_t     ex1Ra;
	pipePkg::regId_t     ex2Ra;
	pipePkg::ex1Ex2Bus_t ex1Ex2;
	pipePkg::ex2FwdBus_t ex2Fwd;
	pipePkg::wbBus_t     wb;

	// ------------------------------------------------------------------------
	// Stages
	// ------------------------------------------------------------------------
	fetchStage #(
		.ImemAddrBits (ImemAddrBits)
	) fetch0 (
		.CLK      (CLK),
		.RSTB     (RSTB),
		.imemLoad (imemLoad),
		.stall    (stall),
		.ifId     (ifId)
	);

	regFile regFile0 (
		.CLK  (CLK),
		.RSTB (RSTB),
		.xa   (xa),
		.xd   (xd),
		.wb   (wb)
	);

	decodeStage decode0 (
		.CLK     (CLK),
		.RSTB    (RSTB),
		.ifId    (ifId),
		.xd      (xd),
		.ex1Ctrl (ex1Ctrl),
		.ex1Ra   (ex1Ra),
		.ex2Ra   (ex2Ra),
		.xa      (xa),
		.stall   (stall),
		.idEx1   (idEx1)
	);

	ex1Stage ex10 (
		.CLK     (CLK),
		.RSTB    (RSTB),
		.idEx1   (idEx1),
		.ex2Fwd  (ex2Fwd),
		.wb      (wb),
		.ex1Ex2  (ex1Ex2),
		.ex1Ctrl (ex1Ctrl),
		.ex1Ra   (ex1Ra)
	);

	ex2Stage ex20 (
		.CLK    (CLK),
		.RSTB   (RSTB),
		.ex1Ex2 (ex1Ex2),
		.ex2Fwd (ex2Fwd),
		.ex2Ra  (ex2Ra),
		.wb     (wb)
	);

	// Retirement observation, one strobe per non-NOP instruction
	assign wbValid = wb.write;
	assign wbReg   = wb.ra;
	assign wbData  = wb.rd;

endmodule

//--- hdl/ex2Stage.sv
// Execute stage 2: forwarding from write-back and the add-4 datapath
// Holds the execute-2/write-back register and builds the retiring result
module ex2Stage
(
	input  logic                 CLK,
	input  logic                 RSTB,
	input  pipePkg::ex1Ex2Bus_t  ex1Ex2,
	output pipePkg::ex2FwdBus_t  ex2Fwd,
	output pipePkg::regId_t      ex2Ra,
	output pipePkg::wbBus_t      wb
);

	logic            fwd2;
	logic            skip2;
	pipePkg::data_t  adderIn;
	pipePkg::data_t  adderOut;
	logic            writeQ;
	pipePkg::regId_t raQ;
	logic            skipQ;
	pipePkg::data_t  adderInQ;
	pipePkg::data_t  adderOutQ;

	// ------------------------------------------------------------------------
	// Forwarding and add-4
	// ------------------------------------------------------------------------
	// ADD4 and MOV were allowed past decode with a stale operand when the
	// Producer one ahead was still adding, that producer is now in write-back
	assign fwd2    = ex1Ex2.xmEx1 && (ex1Ex2.ctrl.add4 || ex1Ex2.ctrl.mov) && wb.write;
	assign adderIn = fwd2 ? wb.rd : ex1Ex2.xd;

	assign adderOut = adderIn + pipePkg::data_t'(4);

	// Only ADD4 and ADD1 take the adder output
	assign skip2 = !(ex1Ex2.ctrl.add4 || ex1Ex2.ctrl.add1);

	// A MOV or SUB3 here can serve execute 1 with the forwarded adder input
	assign ex2Fwd = '{ex2AdderIn: adderIn, ex2Ctrl: ex1Ex2.ctrl};
	assign ex2Ra  = ex1Ex2.ra;

	// ------------------------------------------------------------------------
	// Execute-2/write-back register
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			writeQ <= 1'b0;
			raQ    <= '0;
			skipQ  <= 1'b0;
		end
		else
		begin
			// Any non-NOP op retires a register write
			writeQ <= |ex1Ex2.ctrl;
			raQ    <= ex1Ex2.ra;
			skipQ  <= skip2;
		end
	end

	// Both adder sides are kept, the select mux sits in write-back
	always_ff @(posedge CLK)
	begin
		adderInQ  <= adderIn;
		adderOutQ <= adderOut;
	end

	// Result mux in write-back
	assign wb = '{write: writeQ, ra: raQ, rd: skipQ ? adderInQ : adderOutQ};

endmodule

//--- hdl/ex1Stage.sv
// Execute stage 1: operand forwarding and the subtract-3 datapath
// Holds the execute-1/execute-2 register
module ex1Stage
(
	input  logic                 CLK,
	input  logic                 RSTB,
	input  pipePkg::idEx1Bus_t   idEx1,
	input  pipePkg::ex2FwdBus_t  ex2Fwd,
	input  pipePkg::wbBus_t      wb,
	output pipePkg::ex1Ex2Bus_t  ex1Ex2,
	output pipePkg::opCtrl_t     ex1Ctrl,
	output pipePkg::regId_t      ex1Ra
);

	logic             prioSel;
	logic             fwd1;
	logic             skip1;
	pipePkg::data_t   prioXd;
	pipePkg::data_t   adderIn;
	pipePkg::data_t   adderOut;
	pipePkg::data_t   stageOut;
	pipePkg::opCtrl_t ctrlQ;
	pipePkg::regId_t  raQ;
	logic             xmEx1Q;
	pipePkg::data_t   xdQ;

	// Decode uses these for its hazard check against this stage
	assign ex1Ctrl = idEx1.ctrl;
	assign ex1Ra   = idEx1.ra;

	// ------------------------------------------------------------------------
	// Forwarding and subtract-3
	// ------------------------------------------------------------------------
	always_comb
	begin
		// Nearest producer wins, but only SUB3 and MOV are finished in execute 2
		prioSel = idEx1.xmEx1 && (ex2Fwd.ex2Ctrl.sub3 || ex2Fwd.ex2Ctrl.mov);
		fwd1    = prioSel || (idEx1.xmEx2 && wb.write);
		// Execute 2's adder input already carries its own write-back forward
		prioXd  = prioSel ? ex2Fwd.ex2AdderIn : wb.rd;
		adderIn = fwd1 ? prioXd : idEx1.xd;

		adderOut = adderIn - pipePkg::data_t'(3);

		// MOV and ADD4 pass the operand through unchanged
		skip1    = !(idEx1.ctrl.sub3 || idEx1.ctrl.add1);
		stageOut = skip1 ? adderIn : adderOut;
	end

	// ------------------------------------------------------------------------
	// Execute-1/execute-2 register
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			ctrlQ  <= '0;
			raQ    <= '0;
			xmEx1Q <= 1'b0;
		end
		else
		begin
			ctrlQ  <= idEx1.ctrl;
			raQ    <= idEx1.ra;
			xmEx1Q <= idEx1.xmEx1;
		end
	end

	always_ff @(posedge CLK)
	begin
		xdQ <= stageOut;
	end

	assign ex1Ex2 = '{ctrl: ctrlQ, ra: raQ, xd: xdQ, xmEx1: xmEx1Q};

	// Memory words and bubbles must reach here with one-hot or empty flags
	oneHotOpcode: assert property (@(posedge CLK) disable iff (!RSTB)
		$onehot0(idEx1.ctrl))
		else $error("More than one opcode flag set in execute 1");

endmodule

//--- hdl/decodeStage.sv
// Decode stage: source read, compare station and stall detection
// Holds the decode/execute-1 register and puts a bubble into it on a stall
module decodeStage
(
	input  logic                CLK,
	input  logic                RSTB,
	input  pipePkg::ifIdBus_t   ifId,
	input  pipePkg::data_t      xd,
	input  pipePkg::opCtrl_t    ex1Ctrl,
	input  pipePkg::regId_t     ex1Ra,
	input  pipePkg::regId_t     ex2Ra,
	output pipePkg::regId_t     xa,
	output logic                stall,
	output pipePkg::idEx1Bus_t  idEx1
);

	logic             xmEx1;
	logic             xmEx2;
	logic             needEarly;
	logic             lateResult;
	pipePkg::opCtrl_t ctrlQ;
	pipePkg::regId_t  raQ;
	logic             xmEx1Q;
	logic             xmEx2Q;
	pipePkg::data_t   xdQ;

	// Source register goes to the register file read port
	assign xa = ifId.xa;

	// ------------------------------------------------------------------------
	// Compare station
	// ------------------------------------------------------------------------
	// Matches are not qualified by the producer op here; every consumer of
	// These flags checks the producer's own control bits later
	assign xmEx1 = (ifId.xa == ex1Ra);
	assign xmEx2 = (ifId.xa == ex2Ra);

	// SUB3 and ADD1 need their operand at the start of execute 1
	assign needEarly = ifId.ctrl.sub3 || ifId.ctrl.add1;

	// ADD4 and ADD1 only have their result at the end of execute 2
	assign lateResult = ex1Ctrl.add4 || ex1Ctrl.add1;

	// Only case forwarding cannot cover, so wait one cycle
	assign stall = xmEx1 && needEarly && lateResult;

	// ------------------------------------------------------------------------
	// Decode/execute-1 register
	// ------------------------------------------------------------------------
	// On a stall the flags are cleared, the rest of the word is don't-care
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			ctrlQ  <= '0;
			raQ    <= '0;
			xmEx1Q <= 1'b0;
			xmEx2Q <= 1'b0;
		end
		else
		begin
			ctrlQ  <= stall ? '0 : ifId.ctrl;
			raQ    <= ifId.ra;
			xmEx1Q <= xmEx1;
			xmEx2Q <= xmEx2;
		end
	end

	// Source operand value
	always_ff @(posedge CLK)
	begin
		xdQ <= xd;
	end

	assign idEx1 = '{ctrl: ctrlQ, ra: raQ, xd: xdQ, xmEx1: xmEx1Q, xmEx2: xmEx2Q};

	// The bubble removes the late producer from execute 1, so a stall
	// Can never be requested again for the same instruction
	singleCycleStall: assert property (@(posedge CLK) disable iff (!RSTB)
		stall |=> !stall)
		else $error("Stall held for two consecutive cycles");

endmodule

//--- hdl/regFile.sv
// Sixteen-entry data register file, cleared on reset
// One write port from write-back; the read port sees a same-cycle write
module regFile
(
	input  logic             CLK,
	input  logic             RSTB,
	input  pipePkg::regId_t  xa,
	output pipePkg::data_t   xd,
	input  pipePkg::wbBus_t  wb
);

	localparam int NumRegs = 2 ** pipePkg::REG_ID_W;

	pipePkg::data_t regs [NumRegs];

	// ------------------------------------------------------------------------
	// Write port
	// ------------------------------------------------------------------------
	// All registers start at zero so an untouched register reads a defined value
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			for (int i = 0; i < NumRegs; i++)
				regs[i] <= '0;
		end
		else if (wb.write)
		begin
			regs[wb.ra] <= wb.rd;
		end
	end

	// ------------------------------------------------------------------------
	// Read port with bypass
	// ------------------------------------------------------------------------
	// An instruction three behind its producer reads in decode while the
	// Producer is in write-back, so the retiring value is passed straight over
	always_comb
	begin
		if (wb.write && (wb.ra == xa))
			xd = wb.rd;
		else
			xd = regs[xa];
	end

endmodule

//--- hdl/fetchStage.sv
// Fetch stage with the program counter and the instruction memory
// The memory is filled through imemLoad during reset, then read at the PC
module fetchStage
#(
	parameter int ImemAddrBits = 6
)
(
	input  logic                CLK,
	input  logic                RSTB,
	input  pipePkg::imemLoad_t  imemLoad,
	input  logic                stall,
	output pipePkg::ifIdBus_t   ifId
);

	localparam int ImemDepth = 2 ** ImemAddrBits;

	logic [pipePkg::INSTR_W-1:0] imem [ImemDepth];
	logic [ImemAddrBits-1:0]     pc;
	logic [ImemAddrBits-1:0]     loadAddr;
	logic [pipePkg::INSTR_W-1:0] instr;
	pipePkg::ifIdBus_t           ifIdNext;

	// ------------------------------------------------------------------------
	// Instruction memory
	// ------------------------------------------------------------------------
	// Load address is resized to the memory depth
	assign loadAddr = ImemAddrBits'(imemLoad.addr);

	always_ff @(posedge CLK)
	begin
		if (imemLoad.we)
			imem[loadAddr] <= imemLoad.data;
	end

	// Asynchronous read at the current PC
	assign instr = imem[pc];

	// Split the word into opcode flags and register fields
	always_comb
	begin
		ifIdNext.ctrl.mov  = instr[pipePkg::OP_MOV_BIT];
		ifIdNext.ctrl.sub3 = instr[pipePkg::OP_SUB3_BIT];
		ifIdNext.ctrl.add4 = instr[pipePkg::OP_ADD4_BIT];
		ifIdNext.ctrl.add1 = instr[pipePkg::OP_ADD1_BIT];
		ifIdNext.ra        = instr[pipePkg::RA_LSB +: pipePkg::REG_ID_W];
		ifIdNext.xa        = instr[pipePkg::XA_LSB +: pipePkg::REG_ID_W];
	end

	// ------------------------------------------------------------------------
	// PC and fetch/decode register
	// ------------------------------------------------------------------------
	// Both hold while decode stalls, the PC wraps so the program repeats
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			pc   <= '0;
			ifId <= '0;
		end
		else if (!stall)
		begin
			pc   <= pc + 1'b1;
			ifId <= ifIdNext;
		end
	end

	// A stalled instruction must still be in decode on the next cycle
	pcHoldOnStall: assert property (@(posedge CLK) disable iff (!RSTB)
		stall |=> ($stable(pc) && $stable(ifId)))
		else $error("PC or fetch/decode register moved during a stall");

	// Loading the program is only allowed while the pipeline is held in reset
	loadOnlyInReset: assert property (@(posedge CLK) imemLoad.we |-> !RSTB)
		else $error("Instruction memory written outside reset");

endmodule

//--- hdl/pipePkg.sv
// Widths, opcode layout and stage-register structs shared by the pipeline
// RTL files refer to these by scoped name, for example pipePkg::data_t
package pipePkg;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------
	localparam int DATA_W      = 16;
	localparam int REG_ID_W    = 4;
	localparam int INSTR_W     = 32;
	// The load port can address a 64-word instruction memory
	localparam int IMEM_ADDR_W = 6;

	// One-hot opcode flags in the top nibble, an all-zero word is a NOP
	localparam int OP_MOV_BIT  = 31;
	localparam int OP_SUB3_BIT = 30;
	localparam int OP_ADD4_BIT = 29;
	localparam int OP_ADD1_BIT = 28;

	// Destination register in bits 7..4, source register in bits 3..0
	localparam int RA_LSB = 4;
	localparam int XA_LSB = 0;

	typedef logic [DATA_W-1:0]   data_t;
	typedef logic [REG_ID_W-1:0] regId_t;

	// ------------------------------------------------------------------------
	// Stage-register contents
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic mov;
		logic sub3;
		logic add4;
		logic add1;
	} opCtrl_t;

	// One instruction-memory write, legal only while the pipeline is in reset
	typedef struct packed {
		logic                   we;
		logic [IMEM_ADDR_W-1:0] addr;
		logic [INSTR_W-1:0]     data;
	} imemLoad_t;

	typedef struct packed {
		opCtrl_t ctrl;
		regId_t  ra;
		regId_t  xa;
	} ifIdBus_t;

	// xmEx1/xmEx2 flag a source match one and two instructions ahead
	typedef struct packed {
		opCtrl_t ctrl;
		regId_t  ra;
		data_t   xd;
		logic    xmEx1;
		logic    xmEx2;
	} idEx1Bus_t;

	typedef struct packed {
		opCtrl_t ctrl;
		regId_t  ra;
		data_t   xd;
		logic    xmEx1;
	} ex1Ex2Bus_t;

	// Execute-2 help offered to execute 1 in the same cycle
	typedef struct packed {
		data_t   ex2AdderIn;
		opCtrl_t ex2Ctrl;
	} ex2FwdBus_t;

	// Retiring result: register-file write, forwarding source and top output
	typedef struct packed {
		logic   write;
		regId_t ra;
		data_t  rd;
	} wbBus_t;

endpackage
